// File: source/warships_config.svh
// game-wide constants: fleet size, grid address width, link depth, empty coordinate
`ifndef WARSHIPS_CONFIG_SVH
`define WARSHIPS_CONFIG_SVH

// ships each player places before the game starts
`define WS_FLEET_SIZE 10

// grid address, upper nibble row and lower nibble column
`define WS_GRID_AW 8

// register stages on the lines from the other board
`define WS_LINK_STAGES 2

// coordinate value meaning nothing selected
`define WS_NO_COORD 8'hff

`endif

// File: source/grid_pkg.sv
// grid types: cell coordinate vector and cell status encoding
`include "warships_config.svh"

package grid_pkg;

    // ------------------------------
    // coordinates
    // ------------------------------
    typedef logic [`WS_GRID_AW-1:0] grid_coord_t; // {row, column}

    // ------------------------------
    // cell contents
    // ------------------------------
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_SHIP  = 2'b01, // own ship, not yet hit
        CELL_MISS  = 2'b10,
        CELL_HIT   = 2'b11
    } cell_status_t;

endpackage

// File: source/game_pkg.sv
// game types: ship count vector and game state encoding
`include "warships_config.svh"

package game_pkg;

    typedef logic [3:0] ship_count_t; // ships still afloat

    // neighbouring states differ in one bit along the usual path
    typedef enum logic [3:0] {
        WAIT_FOR_BEGIN   = 4'b0000, // placement and start
        PUT_SHIP         = 4'b0001,
        WAIT_FOR_ENEMY   = 4'b0011,
        WAIT_FOR_SHOT    = 4'b0010,
        MEM_READ         = 4'b0110, // answering a peer shot
        MEM_CHECK        = 4'b0111,
        COMPARE_AND_SAVE = 4'b0101,
        SHOT             = 4'b0100, // our own shot
        WAIT_FOR_ANSWER  = 4'b1100,
        SAVE_RESULT      = 4'b1101,
        WIN              = 4'b1111,
        LOSE             = 4'b1110
    } game_state_t;

endpackage

// File: source/grid_ram.sv
// grid_ram: 256 x 2-bit cell store, registered write-first read, row sweep clear
`timescale 1ns/10ps
`include "warships_config.svh"

module grid_ram import grid_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  grid_coord_t  addr,
    input  cell_status_t wdata,
    input  logic         we,
    output cell_status_t rdata
);

    localparam int COL_W = `WS_GRID_AW / 2;
    localparam int ROW_W = `WS_GRID_AW - COL_W;

    cell_status_t     mem [1 << ROW_W][1 << COL_W];
    logic [ROW_W-1:0] sweep_row; // row being cleared
    logic             clearing;

    // sweep runs for one row per cycle once reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            clearing  <= 1'b1;
            sweep_row <= '0;
        end else if (clearing) begin
            sweep_row <= sweep_row + 1'b1;
            if (&sweep_row) begin
                clearing <= 1'b0; // last row done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            for (int c = 0; c < (1 << COL_W); c++) begin
                mem[sweep_row][c] <= CELL_EMPTY;
            end
        end else if (we) begin
            mem[addr[`WS_GRID_AW-1:COL_W]][addr[COL_W-1:0]] <= wdata;
        end
    end

    // new data is seen on the read port in the write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[addr[`WS_GRID_AW-1:COL_W]][addr[COL_W-1:0]];
        end
    end

    // controller must stay off the store until the sweep has finished
    a_no_write_in_sweep: assert property (@(posedge clk) disable iff (rst) clearing |-> !we)
        else $error("grid write while clear sweep is running");

endmodule

// File: source/peer_link.sv
// peer_link: register chain for ready, hit and coordinate lines from the other board
`timescale 1ns/10ps
`include "warships_config.svh"

module peer_link import grid_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        ready_in,
    input  logic        hit_in,
    input  grid_coord_t cords_in,
    output logic        peer_ready,
    output logic        peer_hit,
    output grid_coord_t peer_cords
);

    localparam int STAGES = `WS_LINK_STAGES;

    logic [STAGES-1:0] ready_q;
    logic [STAGES-1:0] hit_q;
    grid_coord_t       cords_q [STAGES];

    // handshake lines, cleared so nothing looks valid after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q <= '0;
            hit_q   <= '0;
        end else begin
            ready_q[0] <= ready_in;
            hit_q[0]   <= hit_in;
            for (int i = 1; i < STAGES; i++) begin
                ready_q[i] <= ready_q[i-1];
                hit_q[i]   <= hit_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        cords_q[0] <= cords_in; // coordinates only matter while ready is high
        for (int i = 1; i < STAGES; i++) begin
            cords_q[i] <= cords_q[i-1];
        end
    end

    assign peer_ready = ready_q[STAGES-1];
    assign peer_hit   = hit_q[STAGES-1];
    assign peer_cords = cords_q[STAGES-1];

endmodule

// File: source/main_fsm.sv
// game control FSM with placement, turn exchange, ship counts and win/lose
`timescale 1ns/10ps
`include "warships_config.svh"

module main_fsm import grid_pkg::*, game_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_btn,
    input  grid_coord_t  my_grid_cords,
    input  grid_coord_t  en_grid_cords,
    input  logic         peer_ready,
    input  logic         peer_hit,
    input  grid_coord_t  peer_cords,
    input  cell_status_t my_rdata,
    input  cell_status_t en_rdata,
    output logic         start_btn_en,
    output grid_coord_t  my_addr,
    output cell_status_t my_wdata,
    output logic         my_we,
    output grid_coord_t  en_addr,
    output cell_status_t en_wdata,
    output logic         en_we,
    output logic         ready1,
    output logic         hit1,
    output grid_coord_t  ship_cords_out,
    output ship_count_t  my_ctr,
    output ship_count_t  en_ctr,
    output game_state_t  state_out
);

    localparam ship_count_t FLEET = ship_count_t'(`WS_FLEET_SIZE);

    game_state_t  state, state_nxt;
    ship_count_t  my_ctr_nxt, en_ctr_nxt;
    logic         ready1_nxt, hit1_nxt, start_btn_en_nxt;
    logic         my_we_nxt, en_we_nxt;
    grid_coord_t  my_addr_nxt, en_addr_nxt, ship_cords_out_nxt;
    cell_status_t my_wdata_nxt, en_wdata_nxt;

    logic place_valid, start_ok, target_valid, own_hit;

    assign place_valid  = (my_grid_cords != `WS_NO_COORD) && (my_ctr != '0);
    assign start_ok     = start_btn && (my_ctr == '0); // whole fleet placed
    assign target_valid = en_grid_cords != `WS_NO_COORD;
    assign own_hit      = (my_rdata == CELL_SHIP) || (my_rdata == CELL_HIT);

    assign state_out = state;

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_FOR_BEGIN: begin
                if (place_valid) begin
                    state_nxt = PUT_SHIP;
                end else if (start_ok) begin
                    // idle peer means we fire first
                    state_nxt = peer_ready ? WAIT_FOR_ENEMY : WAIT_FOR_SHOT;
                end
            end
            PUT_SHIP:         state_nxt = WAIT_FOR_BEGIN;
            WAIT_FOR_ENEMY: begin
                if (en_ctr == '0) begin
                    state_nxt = WIN;
                end else if (my_ctr == '0) begin
                    state_nxt = LOSE;
                end else if (peer_hit && peer_ready) begin
                    state_nxt = MEM_READ; // incoming shot
                end
            end
            WAIT_FOR_SHOT:    state_nxt = target_valid ? SHOT : WAIT_FOR_SHOT;
            MEM_READ:         state_nxt = MEM_CHECK;
            MEM_CHECK:        state_nxt = COMPARE_AND_SAVE;
            COMPARE_AND_SAVE: state_nxt = peer_ready ? WAIT_FOR_SHOT : COMPARE_AND_SAVE;
            SHOT:             state_nxt = WAIT_FOR_ANSWER;
            WAIT_FOR_ANSWER:  state_nxt = peer_ready ? SAVE_RESULT : WAIT_FOR_ANSWER;
            SAVE_RESULT:      state_nxt = peer_ready ? WAIT_FOR_ENEMY : SAVE_RESULT;
            WIN, LOSE:        state_nxt = state; // game over
            default:          state_nxt = WAIT_FOR_BEGIN;
        endcase
    end

    // ------------------------------
    // output decode
    // ------------------------------
    always_comb begin
        my_ctr_nxt         = my_ctr;
        en_ctr_nxt         = en_ctr;
        ready1_nxt         = ready1;
        hit1_nxt           = hit1;
        start_btn_en_nxt   = start_btn_en;
        my_we_nxt          = my_we;
        en_we_nxt          = en_we;
        my_addr_nxt        = my_addr;
        en_addr_nxt        = en_addr;
        my_wdata_nxt       = my_wdata;
        en_wdata_nxt       = en_wdata;
        ship_cords_out_nxt = ship_cords_out;
        case (state)
            WAIT_FOR_BEGIN: begin
                if (place_valid) begin
                    my_ctr_nxt   = my_ctr - 1'b1;
                    my_we_nxt    = 1'b1;
                    my_addr_nxt  = my_grid_cords;
                    my_wdata_nxt = CELL_SHIP;
                end else if (start_ok) begin
                    ready1_nxt       = 1'b1;
                    hit1_nxt         = 1'b0;
                    my_ctr_nxt       = FLEET; // now counts ships left afloat
                    en_ctr_nxt       = FLEET;
                    start_btn_en_nxt = 1'b0;
                end else begin
                    ready1_nxt = 1'b0;
                end
            end
            PUT_SHIP: begin
                ready1_nxt = 1'b0;
                my_we_nxt  = 1'b0;
            end
            WAIT_FOR_ENEMY: begin
                if (en_ctr == '0 || my_ctr == '0) begin
                    ready1_nxt = ready1; // outputs frozen at the end
                end else if (peer_hit && peer_ready) begin
                    my_addr_nxt = peer_cords; // look up the targeted cell
                    my_we_nxt   = 1'b0;
                    ready1_nxt  = 1'b0;
                end else begin
                    ready1_nxt = 1'b1;
                    hit1_nxt   = 1'b0;
                end
            end
            WAIT_FOR_SHOT: begin
                ready1_nxt = 1'b1;
                hit1_nxt   = target_valid;
                if (target_valid) begin
                    ship_cords_out_nxt = en_grid_cords;
                end
            end
            MEM_READ:         ready1_nxt = 1'b0; // read data lands next edge
            MEM_CHECK: begin
                ready1_nxt   = 1'b1;
                hit1_nxt     = own_hit;
                my_addr_nxt  = peer_cords;
                my_we_nxt    = 1'b1;
                my_wdata_nxt = own_hit ? CELL_HIT : CELL_MISS;
                if (own_hit) begin
                    my_ctr_nxt = my_ctr - 1'b1;
                end
            end
            COMPARE_AND_SAVE: begin
                ready1_nxt = 1'b1;
                my_we_nxt  = 1'b0;
                if (peer_ready) begin
                    hit1_nxt = 1'b0; // answer taken
                end
            end
            SHOT: begin
                ready1_nxt = 1'b1;
                hit1_nxt   = 1'b1;
            end
            WAIT_FOR_ANSWER: begin
                if (peer_ready) begin
                    ready1_nxt   = 1'b1;
                    en_addr_nxt  = peer_cords; // echoed target
                    en_we_nxt    = 1'b1;
                    en_wdata_nxt = peer_hit ? CELL_HIT : CELL_MISS;
                    if (peer_hit) begin
                        en_ctr_nxt = en_ctr - 1'b1;
                    end
                end
            end
            SAVE_RESULT: begin
                if (peer_ready) begin
                    ready1_nxt = 1'b1;
                    hit1_nxt   = 1'b0;
                    en_we_nxt  = 1'b0;
                end
            end
            default: ready1_nxt = ready1;
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WAIT_FOR_BEGIN;
            my_ctr       <= FLEET;
            en_ctr       <= FLEET;
            ready1       <= 1'b0;
            hit1         <= 1'b0;
            start_btn_en <= 1'b1;
            my_we        <= 1'b0;
            en_we        <= 1'b0;
        end else begin
            state        <= state_nxt;
            my_ctr       <= my_ctr_nxt;
            en_ctr       <= en_ctr_nxt;
            ready1       <= ready1_nxt;
            hit1         <= hit1_nxt;
            start_btn_en <= start_btn_en_nxt;
            my_we        <= my_we_nxt;
            en_we        <= en_we_nxt;
        end
    end

    always_ff @(posedge clk) begin
        my_addr        <= my_addr_nxt;
        en_addr        <= en_addr_nxt;
        my_wdata       <= my_wdata_nxt;
        en_wdata       <= en_wdata_nxt;
        ship_cords_out <= ship_cords_out_nxt;
    end

    a_my_ctr_range: assert property (@(posedge clk) disable iff (rst) my_ctr <= FLEET)
        else $error("own ship count above fleet size");
    a_one_writer: assert property (@(posedge clk) disable iff (rst) !(my_we && en_we))
        else $error("both grid stores written in one cycle");

endmodule

// File: source/warships_top.sv
// warships_top: peer link, game control and the own and enemy grid stores
`timescale 1ns/10ps
`include "warships_config.svh"

module warships_top import grid_pkg::*, game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_btn,
    input  grid_coord_t my_grid_cords,  // placement
    input  grid_coord_t en_grid_cords,  // target
    input  logic        ready2,
    input  logic        hit2,
    input  grid_coord_t ship_cords_in,
    output logic        start_btn_en,
    output ship_count_t my_ctr,
    output ship_count_t en_ctr,
    output game_state_t state_out,
    output logic        ready1,
    output logic        hit1,
    output grid_coord_t ship_cords_out
);

    logic         peer_ready, peer_hit;
    grid_coord_t  peer_cords;
    grid_coord_t  my_addr, en_addr;
    cell_status_t my_wdata, en_wdata, my_rdata, en_rdata;
    logic         my_we, en_we;

    // ------------------------------
    // other board
    // ------------------------------
    peer_link u_peer_link (
        .clk        (clk),
        .rst        (rst),
        .ready_in   (ready2),
        .hit_in     (hit2),
        .cords_in   (ship_cords_in),
        .peer_ready (peer_ready),
        .peer_hit   (peer_hit),
        .peer_cords (peer_cords)
    );

    main_fsm u_main_fsm (
        .clk            (clk),
        .rst            (rst),
        .start_btn      (start_btn),
        .my_grid_cords  (my_grid_cords),
        .en_grid_cords  (en_grid_cords),
        .peer_ready     (peer_ready),
        .peer_hit       (peer_hit),
        .peer_cords     (peer_cords),
        .my_rdata       (my_rdata),
        .en_rdata       (en_rdata),
        .start_btn_en   (start_btn_en),
        .my_addr        (my_addr),
        .my_wdata       (my_wdata),
        .my_we          (my_we),
        .en_addr        (en_addr),
        .en_wdata       (en_wdata),
        .en_we          (en_we),
        .ready1         (ready1),
        .hit1           (hit1),
        .ship_cords_out (ship_cords_out),
        .my_ctr         (my_ctr),
        .en_ctr         (en_ctr),
        .state_out      (state_out)
    );

    // ------------------------------
    // grids, both swept clear by rst
    // ------------------------------
    grid_ram u_my_grid (
        .clk   (clk),
        .rst   (rst),
        .addr  (my_addr),
        .wdata (my_wdata),
        .we    (my_we),
        .rdata (my_rdata)
    );

    grid_ram u_en_grid (
        .clk   (clk),
        .rst   (rst),
        .addr  (en_addr),
        .wdata (en_wdata),
        .we    (en_we),
        .rdata (en_rdata)
    );

endmodule

// File: dv/tb_clock_gen.sv
// tb_clock_gen: free running testbench clock
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk; // first rising edge at half a period
    end

endmodule

// File: dv/warships_tb.sv
// warships_tb: opponent model, answer reference, compare tasks and two full games
`timescale 1ns/10ps
`include "warships_config.svh"

module warships_tb import grid_pkg::*, game_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int SWEEP_CYCLES = (1 << (`WS_GRID_AW / 2)) + 2; // one row per cycle
    localparam int MAX_CYCLES   = 4000;
    localparam int CELLS        = 1 << `WS_GRID_AW;
    localparam ship_count_t FLEET = ship_count_t'(`WS_FLEET_SIZE);

    logic        clk, rst, start_btn, ready2, hit2;
    grid_coord_t my_grid_cords, en_grid_cords, ship_cords_in;
    logic        start_btn_en, ready1, hit1;
    ship_count_t my_ctr, en_ctr;
    game_state_t state_out;
    grid_coord_t ship_cords_out;

    bit          placed [CELLS];               // cells the DUT was given
    grid_coord_t placed_list [`WS_FLEET_SIZE];
    bit          opp_ship [CELLS];             // opponent fleet
    grid_coord_t opp_list [`WS_FLEET_SIZE];
    grid_coord_t shot_coord;                   // last opponent shot
    ship_count_t exp_my, exp_en;
    int          cycles = 0;
    int          answers_checked = 0;
    int          shots_taken = 0;
    logic        ready1_prev = 1'b0;

    tb_clock_gen #(.PERIOD_NS(100)) u_clk (.clk(clk));

    warships_top warships_top_i (
        .clk            (clk),
        .rst            (rst),
        .start_btn      (start_btn),
        .my_grid_cords  (my_grid_cords),
        .en_grid_cords  (en_grid_cords),
        .ready2         (ready2),
        .hit2           (hit2),
        .ship_cords_in  (ship_cords_in),
        .start_btn_en   (start_btn_en),
        .my_ctr         (my_ctr),
        .en_ctr         (en_ctr),
        .state_out      (state_out),
        .ready1         (ready1),
        .hit1           (hit1),
        .ship_cords_out (ship_cords_out)
    );

    // a peer shot hits exactly the cells that were placed
    function automatic logic expect_answer(grid_coord_t c);
        return placed[c];
    endfunction

    function automatic grid_coord_t random_coord();
        return grid_coord_t'($urandom_range(254, 0)); // never the empty value
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_coord(grid_coord_t got, grid_coord_t exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_count(ship_count_t got, ship_count_t exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_state(game_state_t got, game_state_t exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s is %s, expected %s",
                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic wait_state(game_state_t s);
        while (state_out != s) begin
            @(negedge clk);
        end
    endtask

    // ------------------------------
    // game steps
    // ------------------------------
    task automatic reset_dut();
        rst           = 1'b1;
        start_btn     = 1'b0;
        my_grid_cords = `WS_NO_COORD;
        en_grid_cords = `WS_NO_COORD;
        ready2        = 1'b0;
        hit2          = 1'b0;
        ship_cords_in = `WS_NO_COORD;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_flag(ready1, 1'b0, "ready1 after reset");
        check_flag(hit1, 1'b0, "hit1 after reset");
        check_flag(start_btn_en, 1'b1, "start_btn_en after reset");
        check_count(my_ctr, FLEET, "my_ctr after reset");
        check_count(en_ctr, FLEET, "en_ctr after reset");
        check_state(state_out, WAIT_FOR_BEGIN, "state after reset");
        foreach (placed[i]) placed[i] = 1'b0;
        repeat (SWEEP_CYCLES) @(negedge clk); // both stores clearing
    endtask

    task automatic place_fleet();
        grid_coord_t c;
        exp_my = FLEET;
        for (int i = 0; i < `WS_FLEET_SIZE; i++) begin
            do begin
                c = random_coord();
            end while (placed[c]);
            placed[c]      = 1'b1;
            placed_list[i] = c;
            wait_state(WAIT_FOR_BEGIN);
            my_grid_cords = c;
            @(negedge clk);
            my_grid_cords = `WS_NO_COORD;
            exp_my        = exp_my - 1'b1;
            check_count(my_ctr, exp_my, "my_ctr after placement");
            @(negedge clk); // PUT_SHIP
        end
        // fleet complete, extra coordinates change nothing
        for (int i = 0; i < 3; i++) begin
            my_grid_cords = random_coord();
            @(negedge clk);
            my_grid_cords = `WS_NO_COORD;
            check_count(my_ctr, '0, "my_ctr with fleet placed");
            check_state(state_out, WAIT_FOR_BEGIN, "state with fleet placed");
        end
    endtask

    task automatic start_game();
        start_btn = 1'b1;
        @(negedge clk);
        start_btn = 1'b0;
        check_flag(start_btn_en, 1'b0, "start_btn_en after start");
        check_count(my_ctr, FLEET, "my_ctr reload at start");
        check_count(en_ctr, FLEET, "en_ctr reload at start");
        check_state(state_out, WAIT_FOR_SHOT, "state after start");
        exp_my = FLEET;
        exp_en = FLEET;
    endtask

    // DUT fires, opponent answers from its own fleet
    task automatic fire_at(grid_coord_t target);
        logic answer;
        answer = opp_ship[target];
        wait_state(WAIT_FOR_SHOT);
        en_grid_cords = target;
        @(negedge clk);
        en_grid_cords = `WS_NO_COORD;
        while (!(ready1 && hit1)) begin
            @(negedge clk);
        end
        check_coord(ship_cords_out, target, "ship_cords_out during shot");
        ready2        = 1'b1;
        hit2          = answer;
        ship_cords_in = target; // echo
        repeat (`WS_LINK_STAGES) @(negedge clk);
        ready2 = 1'b0;
        hit2   = 1'b0;
        wait_state(WAIT_FOR_ENEMY);
        if (answer) begin
            exp_en = exp_en - 1'b1;
        end
        check_count(en_ctr, exp_en, "en_ctr after answer");
    endtask

    // opponent fires, holds the shot until the answer is up
    task automatic shoot_at_dut(grid_coord_t c);
        wait_state(WAIT_FOR_ENEMY);
        shot_coord    = c;
        shots_taken++;
        ready2        = 1'b1;
        hit2          = 1'b1;
        ship_cords_in = c;
        while (ready1) begin
            @(negedge clk);
        end
        while (!ready1) begin
            @(negedge clk);
        end
        if (expect_answer(c)) begin
            exp_my = exp_my - 1'b1;
        end
        check_state(state_out, COMPARE_AND_SAVE, "state with answer up");
        check_count(my_ctr, exp_my, "my_ctr after peer shot");
        ready2 = 1'b0;
        hit2   = 1'b0;
        wait_state(WAIT_FOR_SHOT);
    endtask

    task automatic hold_state(game_state_t s, string what);
        wait_state(s);
        repeat (8) begin
            @(negedge clk);
            check_state(state_out, s, what);
        end
    endtask

    task automatic pick_opponent_fleet();
        grid_coord_t c;
        foreach (opp_ship[i]) opp_ship[i] = 1'b0;
        for (int i = 0; i < `WS_FLEET_SIZE; i++) begin
            do begin
                c = random_coord();
            end while (opp_ship[c]);
            opp_ship[c] = 1'b1;
            opp_list[i] = c;
        end
    endtask

    task automatic play_to_win();
        grid_coord_t target;
        grid_coord_t c;
        int          turn;
        int          next_ship;
        int          planted;
        turn      = 0;
        next_ship = 0;
        planted   = 0;
        while (exp_en != '0) begin
            if (turn % 2 == 0) begin
                target = opp_list[next_ship]; // sure hit
                next_ship++;
            end else begin
                target = random_coord();
            end
            fire_at(target);
            if (exp_en != '0) begin
                if (turn % 3 == 0 && planted < 3) begin
                    c = placed_list[planted];
                    planted++;
                end else begin
                    do begin
                        c = random_coord();
                    end while (placed[c]); // keeps the DUT fleet afloat
                end
                shoot_at_dut(c);
            end
            turn++;
        end
        hold_state(WIN, "state after last enemy ship");
    endtask

    task automatic play_to_lose();
        grid_coord_t miss;
        for (int k = 0; k <= `WS_FLEET_SIZE; k++) begin
            do begin
                miss = random_coord();
            end while (opp_ship[miss]);
            fire_at(miss);
            if (k < `WS_FLEET_SIZE) begin
                shoot_at_dut(placed_list[k]);
            end
        end
        hold_state(LOSE, "state after last own ship");
    endtask

    // ------------------------------
    // answer compare, watchdog, scenario
    // ------------------------------
    always @(negedge clk) begin
        if (!rst && ready1 && !ready1_prev && state_out == COMPARE_AND_SAVE) begin
            check_flag(hit1, expect_answer(shot_coord), "hit1 answer to peer shot");
            answers_checked++;
        end
        ready1_prev = ready1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: game did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(89));
        shot_coord = `WS_NO_COORD;
        reset_dut();
        pick_opponent_fleet();
        place_fleet();
        start_game();
        play_to_win();

        // second game, DUT fleet sunk
        reset_dut();
        place_fleet();
        start_game();
        play_to_lose();

        if (answers_checked == shots_taken && shots_taken > 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("answer compare ran %0d times for %0d peer shots",
                answers_checked, shots_taken);
            $display("Test failures found");
            $fatal(1, "answer compare incomplete");
        end
    end

endmodule

// File: project.f
+incdir+source
source/grid_pkg.sv
source/game_pkg.sv
source/grid_ram.sv
source/peer_link.sv
source/main_fsm.sv
source/warships_top.sv
dv/tb_clock_gen.sv
dv/warships_tb.sv

// File: Makefile
# Verilator build, run and lint for the warships game core

VERILATOR ?= verilator
TOP       ?= warships_tb
RTL_TOP   ?= warships_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
